/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hw/bicubic_csr.sv */
`timescale 1ns/1ns
`include "bicubic_defs.svh"

module bicubic_csr (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bicubic_regs_pkg::wb_req_t     wb_req,
    output bicubic_regs_pkg::wb_rsp_t     wb_rsp,
    output bicubic_regs_pkg::img_cfg_t    cfg,
    output logic                          start,
    output logic                          mem_we,
    output logic [`BICUBIC_MEM_AW-1:0]    mem_addr,
    output bicubic_pkg::pixel_t           mem_pix,
    input  logic                          frame_done
);

    bicubic_regs_pkg::reg_word_u  wr_word;
    bicubic_regs_pkg::ctrl_t      rd_ctrl;
    bicubic_regs_pkg::img_cfg_t   cfg_q;
    logic [31:0]                  rd_status;
    logic [31:0]                  dat_r_q;
    logic                         req;
    logic                         ack_q;
    logic                         busy;
    logic                         done;
    logic                         start_q;
    logic                         mem_we_q;
    logic                         in_pix_win;
    logic                         ctrl_wr;
    logic                         degenerate;

    // a new request is one not already being acknowledged
    assign req        = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_word    = wb_req.dat_w;
    assign in_pix_win = wb_req.adr >= bicubic_regs_pkg::PIX_BASE;
    assign ctrl_wr    = req && wb_req.we && !busy && wb_req.adr == bicubic_regs_pkg::REG_CTRL;
    // too small to scale, finish without streaming
    assign degenerate = wr_word.ctrl.width < 5'd2 || wr_word.ctrl.height == 4'd0;

    always_comb begin
        rd_ctrl        = '0;
        rd_ctrl.bypass = cfg_q.bypass;
        rd_ctrl.width  = cfg_q.width;
        rd_ctrl.height = cfg_q.height;
        rd_status      = '0;
        rd_status[bicubic_regs_pkg::STAT_BUSY_BIT] = busy;
        rd_status[bicubic_regs_pkg::STAT_DONE_BIT] = done;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            mem_we_q <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            cfg_q    <= '0;
        end else begin
            ack_q    <= req;
            start_q  <= 1'b0;
            mem_we_q <= req && wb_req.we && in_pix_win && !busy;
            if (frame_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (ctrl_wr) begin
                cfg_q.bypass <= wr_word.ctrl.bypass;
                cfg_q.width  <= wr_word.ctrl.width;
                cfg_q.height <= wr_word.ctrl.height;
                if (wr_word.ctrl.start) begin
                    done    <= degenerate;
                    busy    <= !degenerate;
                    start_q <= !degenerate;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_req.adr == bicubic_regs_pkg::REG_CTRL) begin
                dat_r_q <= rd_ctrl;
            end else if (wb_req.adr == bicubic_regs_pkg::REG_STATUS) begin
                dat_r_q <= rd_status;
            end else begin
                dat_r_q <= '0;
            end
        end
        // low address bits already give row * 16 + column
        if (req && wb_req.we && in_pix_win) begin
            mem_addr <= wb_req.adr[`BICUBIC_MEM_AW-1:0];
            mem_pix  <= wr_word.pix.pix;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;
    assign cfg          = cfg_q;
    assign start        = start_q;
    assign mem_we       = mem_we_q;

    ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

/* hw/bicubic_hscale.sv */
`timescale 1ns/1ns

module bicubic_hscale (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bicubic_regs_pkg::img_cfg_t  cfg,
    input  bicubic_pkg::pix_beat_t      src_beat,
    input  logic                        src_valid,
    output logic                        src_ready,
    output bicubic_pkg::pix_beat_t      out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic                        frame_done
);

    // taps -1 9 9 -1, round by 8, shift by 4, clamp to a byte
    function automatic logic [7:0] cubic_ch(input logic [7:0] a, input logic [7:0] b,
                                            input logic [7:0] c, input logic [7:0] d);
        int acc;
        acc = 9 * (int'(b) + int'(c)) - int'(a) - int'(d) + 8;
        acc = acc >>> 4;
        if (acc < 0) begin
            return 8'd0;
        end else if (acc > 255) begin
            return 8'd255;
        end
        return acc[7:0];
    endfunction

    function automatic bicubic_pkg::pixel_t cubic_pix(input bicubic_pkg::pixel_t a,
                                                      input bicubic_pkg::pixel_t b,
                                                      input bicubic_pkg::pixel_t c,
                                                      input bicubic_pkg::pixel_t d);
        bicubic_pkg::pixel_t p;
        p.r = cubic_ch(a.r, b.r, c.r, d.r);
        p.g = cubic_ch(a.g, b.g, c.g, d.g);
        p.b = cubic_ch(a.b, b.b, c.b, d.b);
        return p;
    endfunction

    bicubic_pkg::pixel_t     win [4];
    bicubic_pkg::pixel_t     push_pix;
    bicubic_pkg::pix_beat_t  out_q;
    bicubic_pkg::pix_beat_t  out_next;
    logic [1:0]              fill;
    logic [1:0]              flush_cnt;
    logic [3:0]              row_cnt;
    logic                    win_full;
    logic                    phase;
    logic                    win_last;
    logic                    out_valid_q;
    logic                    frame_done_q;
    logic                    out_free;
    logic                    out_load;
    logic                    push_ok;
    logic                    src_push;
    logic                    flush_push;
    logic                    push;
    logic                    emit;

    assign out_free   = !out_valid_q || out_ready;
    assign out_load   = cfg.bypass ? (src_valid && out_free) : (win_full && out_free);
    // window frees up in the cycle its half-sample leaves
    assign push_ok    = !win_full || (phase && out_load);
    assign src_ready  = cfg.bypass ? out_free : (push_ok && flush_cnt == 2'd0);
    assign src_push   = !cfg.bypass && src_valid && src_ready;
    assign flush_push = !cfg.bypass && push_ok && flush_cnt != 2'd0;
    assign push       = src_push || flush_push;
    assign push_pix   = flush_push ? win[3] : src_beat.pix;
    // from the third push on, the window spans k-1 .. k+2
    assign emit       = push && fill >= 2'd2;

    always_comb begin
        if (cfg.bypass) begin
            out_next = src_beat;
        end else if (!phase) begin
            out_next.pix  = win[1];
            out_next.last = 1'b0;
        end else begin
            out_next.pix  = cubic_pix(win[0], win[1], win[2], win[3]);
            out_next.last = win_last;
        end
    end

    always_ff @(posedge clk) begin
        if (src_push && fill == 2'd0) begin
            // left neighbour replicated from the first pixel
            for (int i = 0; i < 4; i++) begin
                win[i] <= src_beat.pix;
            end
        end else if (push) begin
            win[0] <= win[1];
            win[1] <= win[2];
            win[2] <= win[3];
            win[3] <= push_pix;
        end
        if (out_load) begin
            out_q <= out_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill         <= '0;
            flush_cnt    <= '0;
            win_full     <= 1'b0;
            phase        <= 1'b0;
            win_last     <= 1'b0;
            out_valid_q  <= 1'b0;
            row_cnt      <= '0;
            frame_done_q <= 1'b0;
        end else begin
            if (src_push && fill == 2'd0) begin
                fill <= 2'd1;
            end else if (flush_push && flush_cnt == 2'd1) begin
                fill <= 2'd0;
            end else if (push && fill != 2'd3) begin
                fill <= fill + 2'd1;
            end

            // two extra pushes of the last pixel close the row
            if (src_push && src_beat.last) begin
                flush_cnt <= 2'd2;
            end else if (flush_push) begin
                flush_cnt <= flush_cnt - 2'd1;
            end

            if (emit) begin
                win_full <= 1'b1;
                phase    <= 1'b0;
                win_last <= flush_push && flush_cnt == 2'd1;
            end else if (!cfg.bypass && out_load) begin
                phase <= !phase;
                if (phase) begin
                    win_full <= 1'b0;
                end
            end

            if (out_load) begin
                out_valid_q <= 1'b1;
            end else if (out_ready) begin
                out_valid_q <= 1'b0;
            end

            frame_done_q <= 1'b0;
            if (out_valid_q && out_ready && out_q.last) begin
                if (row_cnt == cfg.height - 4'd1) begin
                    row_cnt      <= '0;
                    frame_done_q <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 4'd1;
                end
            end
        end
    end

    assign out_beat   = out_q;
    assign out_valid  = out_valid_q;
    assign frame_done = frame_done_q;

    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_beat));

endmodule

/* hw/bicubic_pkg.sv */
package bicubic_pkg;

    // one rgb888 pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // one stream beat between data-path blocks
    // last marks the final pixel of a row
    typedef struct packed {
        pixel_t pix;
        logic   last;
    } pix_beat_t;

endpackage

/* hw/bicubic_regs_pkg.sv */
`include "bicubic_defs.svh"

package bicubic_regs_pkg;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`BICUBIC_WB_AW-1:0] adr;
        logic [31:0]               dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // control register layout, start sits in bit 0
    typedef struct packed {
        logic [20:0] rsvd;
        logic [3:0]  height;
        logic [4:0]  width;
        logic        bypass;
        logic        start;
    } ctrl_t;

    // pixel window word, zero-extended rgb888
    typedef struct packed {
        logic [7:0]          rsvd;
        bicubic_pkg::pixel_t pix;
    } pix_word_t;

    // one write word, decoded by address
    typedef union packed {
        ctrl_t     ctrl;
        pix_word_t pix;
    } reg_word_u;

    // image settings seen by the source and the interpolator
    typedef struct packed {
        logic       bypass;
        logic [4:0] width;
        logic [3:0] height;
    } img_cfg_t;

    localparam logic [`BICUBIC_WB_AW-1:0] REG_CTRL   = 8'd0;
    localparam logic [`BICUBIC_WB_AW-1:0] REG_STATUS = 8'd1;
    localparam logic [`BICUBIC_WB_AW-1:0] PIX_BASE   = 8'd128;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

/* hw/bicubic_top.sv */
`timescale 1ns/1ns
`include "bicubic_defs.svh"

module bicubic_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bicubic_regs_pkg::wb_req_t   wb_req,
    output bicubic_regs_pkg::wb_rsp_t   wb_rsp,
    output bicubic_pkg::pix_beat_t      out_beat,
    output logic                        out_valid,
    input  logic                        out_ready
);

    bicubic_regs_pkg::img_cfg_t    cfg;
    bicubic_pkg::pixel_t           mem_pix;
    bicubic_pkg::pix_beat_t        src_beat;
    logic [`BICUBIC_MEM_AW-1:0]    mem_addr;
    logic                          mem_we;
    logic                          start;
    logic                          src_valid;
    logic                          src_ready;
    logic                          frame_done;

    bicubic_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .cfg        (cfg),
        .start      (start),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_pix    (mem_pix),
        .frame_done (frame_done)
    );

    image_source u_source (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .start      (start),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_pix    (mem_pix),
        .src_beat   (src_beat),
        .src_valid  (src_valid),
        .src_ready  (src_ready)
    );

    bicubic_hscale u_hscale (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .src_beat   (src_beat),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .frame_done (frame_done)
    );

endmodule

/* hw/image_source.sv */
`timescale 1ns/1ns
`include "bicubic_defs.svh"

module image_source (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bicubic_regs_pkg::img_cfg_t  cfg,
    input  logic                        start,
    input  logic                        mem_we,
    input  logic [`BICUBIC_MEM_AW-1:0]  mem_addr,
    input  bicubic_pkg::pixel_t         mem_pix,
    output bicubic_pkg::pix_beat_t      src_beat,
    output logic                        src_valid,
    input  logic                        src_ready
);

    localparam int ROW_W = $clog2(`BICUBIC_MAX_H);
    localparam int COL_W = $clog2(`BICUBIC_MAX_W);

    bicubic_pkg::pixel_t           mem [2**`BICUBIC_MEM_AW];
    bicubic_pkg::pix_beat_t        beat_q;
    logic [ROW_W-1:0]              row;
    logic [COL_W-1:0]              col;
    logic [ROW_W-1:0]              nrow;
    logic [COL_W-1:0]              ncol;
    logic [ROW_W-1:0]              ld_row;
    logic [COL_W-1:0]              ld_col;
    logic [`BICUBIC_MEM_AW-1:0]    rd_addr;
    logic                          pending;
    logic                          valid_q;
    logic                          col_last;
    logic                          frame_last;
    logic                          advance;
    logic                          load;

    // row and col point at the pixel currently presented
    assign col_last   = {1'b0, col} == cfg.width - 5'd1;
    assign frame_last = col_last && {1'b0, row} == cfg.height - 4'd1;
    assign advance    = valid_q && src_ready && !frame_last;
    assign load       = pending || advance;

    assign nrow    = col_last ? row + 1'b1 : row;
    assign ncol    = col_last ? '0 : col + 1'b1;
    // first fetch reads the current position, later ones the next
    assign ld_row  = pending ? row : nrow;
    assign ld_col  = pending ? col : ncol;
    assign rd_addr = {ld_row, ld_col};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row     <= '0;
            col     <= '0;
            pending <= 1'b0;
            valid_q <= 1'b0;
        end else if (start) begin
            row     <= '0;
            col     <= '0;
            pending <= 1'b1;
            valid_q <= 1'b0;
        end else if (pending) begin
            pending <= 1'b0;
            valid_q <= 1'b1;
        end else if (valid_q && src_ready) begin
            if (frame_last) begin
                valid_q <= 1'b0;
            end else begin
                row <= nrow;
                col <= ncol;
            end
        end
    end

    // registered read, the beat changes only on a fetch
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_pix;
        end
        if (load) begin
            beat_q.pix  <= mem[rd_addr];
            beat_q.last <= {1'b0, ld_col} == cfg.width - 5'd1;
        end
    end

    assign src_beat  = beat_q;
    assign src_valid = valid_q;

    addr_in_row: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> ({1'b0, row, col} < {1'b0, row, {COL_W{1'b0}}} + 8'(cfg.width)));

endmodule

/* include/bicubic_defs.svh */
`ifndef BICUBIC_DEFS_SVH
`define BICUBIC_DEFS_SVH

// largest supported image, in pixels
`define BICUBIC_MAX_W 16
`define BICUBIC_MAX_H 8

// pixel memory holds MAX_W * MAX_H entries, addressed as row * 16 + column
`define BICUBIC_MEM_AW 7

// wishbone word address width
`define BICUBIC_WB_AW 8

`endif

/* tb.f */
+incdir+include
hw/bicubic_pkg.sv
hw/bicubic_regs_pkg.sv
hw/bicubic_csr.sv
hw/image_source.sv
hw/bicubic_hscale.sv
hw/bicubic_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* testbench/tb_checker.sv */
`timescale 1ns/1ns
`include "bicubic_defs.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bicubic_pkg::pix_beat_t  out_beat,
    input  logic                    out_valid,
    input  logic                    out_ready
);

    bicubic_pkg::pixel_t     img [`BICUBIC_MAX_W * `BICUBIC_MAX_H];
    bicubic_pkg::pix_beat_t  expected [$];
    string                   name = "";
    int                      beat_idx = 0;
    int                      errors = 0;
    int                      reg_errors = 0;

    task automatic set_pixel(input int idx, input bicubic_pkg::pixel_t pix);
        img[idx] = pix;
    endtask

    // register read of the current test against its expected word
    task automatic check_reg(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s %s: expected %h actual %h", name, what, exp_val, act_val);
            reg_errors++;
        end
    endtask

    // cubic half-sample of one channel, between b and c
    function automatic logic [7:0] half_ch(input int a, input int b, input int c, input int d);
        int v;
        v = (9 * b + 9 * c - a - d + 8) / 16;
        if (v < 0) begin
            v = 0;
        end else if (v > 255) begin
            v = 255;
        end
        return 8'(v);
    endfunction

    // neighbours outside the row take the nearest edge pixel
    function automatic bicubic_pkg::pixel_t pixel_at(input int row, input int col, input int width);
        int c;
        c = col;
        if (c < 0) begin
            c = 0;
        end else if (c >= width) begin
            c = width - 1;
        end
        return img[row * `BICUBIC_MAX_W + c];
    endfunction

    task automatic load_frame(input string test_name, input int width, input int height,
                              input logic bypass);
        bicubic_pkg::pixel_t     a;
        bicubic_pkg::pixel_t     b;
        bicubic_pkg::pixel_t     c;
        bicubic_pkg::pixel_t     d;
        bicubic_pkg::pix_beat_t  beat;
        int                      row;
        int                      col;
        name     = test_name;
        beat_idx = 0;
        expected.delete();
        // too small to scale, no output at all
        if (width < 2 || height == 0) begin
            return;
        end
        for (row = 0; row < height; row++) begin
            for (col = 0; col < width; col++) begin
                b         = pixel_at(row, col, width);
                beat.pix  = b;
                beat.last = bypass && col == width - 1;
                expected.push_back(beat);
                if (!bypass) begin
                    a           = pixel_at(row, col - 1, width);
                    c           = pixel_at(row, col + 1, width);
                    d           = pixel_at(row, col + 2, width);
                    beat.pix.r  = half_ch(a.r, b.r, c.r, d.r);
                    beat.pix.g  = half_ch(a.g, b.g, c.g, d.g);
                    beat.pix.b  = half_ch(a.b, b.b, c.b, d.b);
                    beat.last   = col == width - 1;
                    expected.push_back(beat);
                end
            end
        end
    endtask

    task automatic end_frame();
        if (expected.size() != 0) begin
            $display("%s: %0d output beats missing at the end of the frame",
                     name, expected.size());
            errors++;
        end
        expected.delete();
    endtask

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (expected.size() == 0) begin
                $display("%s: unexpected output beat %h after the frame", name, out_beat);
                errors++;
            end else begin
                if (out_beat !== expected[0]) begin
                    $display("MISMATCH %s beat %0d: expected %h actual %h",
                             name, beat_idx, expected[0], out_beat);
                    errors++;
                end
                void'(expected.pop_front());
                beat_idx++;
            end
        end
    end

endmodule

/* testbench/tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lines up with the other inputs, 10 ns after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ns
`include "bicubic_defs.svh"

module tb_top;

    localparam logic [1:0] PAT_RAMP    = 2'd0;
    localparam logic [1:0] PAT_STEP    = 2'd1;
    localparam logic [1:0] PAT_RAND    = 2'd2;
    localparam int         NUM_TESTS   = 8;
    localparam int         DRIVE_DELAY = 10;
    localparam int         SEED        = 32'h7332_235d;

    typedef struct packed {
        logic [4:0] width;
        logic [3:0] height;
        logic       bypass;
        logic [1:0] pattern;
        logic       ready_rand;
    } test_t;

    // width, height, bypass, pixel pattern, random out_ready
    test_t tests [NUM_TESTS] = '{
        '{5'd8,  4'd4, 1'b1, PAT_RAMP, 1'b0},
        '{5'd8,  4'd4, 1'b0, PAT_RAMP, 1'b0},
        '{5'd6,  4'd2, 1'b0, PAT_STEP, 1'b0},
        '{5'd2,  4'd3, 1'b0, PAT_RAND, 1'b0},
        '{5'd16, 4'd8, 1'b0, PAT_RAND, 1'b0},
        '{5'd16, 4'd8, 1'b0, PAT_RAND, 1'b1},
        '{5'd5,  4'd3, 1'b1, PAT_RAND, 1'b1},
        '{5'd1,  4'd2, 1'b0, PAT_RAMP, 1'b0}
    };
    string test_names [NUM_TESTS] = '{
        "ramp_bypass", "ramp_interp", "step_clamp", "width2_edges",
        "random_full", "random_backpressure", "bypass_backpressure", "width1_done"
    };

    logic                       clk;
    logic                       rst_n;
    bicubic_regs_pkg::wb_req_t  wb_req;
    bicubic_regs_pkg::wb_rsp_t  wb_rsp;
    bicubic_pkg::pix_beat_t     out_beat;
    logic                       out_valid;
    logic                       out_ready;
    logic                       ready_rand;
    integer                     pix_seed;
    integer                     ready_seed;

    tb_clkgen clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bicubic_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    tb_checker chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // control word: height 10:7, width 6:2, bypass 1, start 0
    function automatic logic [31:0] ctrl_word(input logic start, input logic bypass,
                                              input logic [4:0] width, input logic [3:0] height);
        return {21'd0, height, width, bypass, start};
    endfunction

    task automatic wait_ack(output logic [31:0] data);
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!wb_rsp.ack);
        data   = wb_rsp.dat_r;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [`BICUBIC_WB_AW-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        wait_ack(unused);
    endtask

    task automatic wb_read(input logic [`BICUBIC_WB_AW-1:0] adr, output logic [31:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = adr;
        wb_req.dat_w = '0;
        wait_ack(data);
    endtask

    task automatic run_test(input int t);
        test_t                tc;
        bicubic_pkg::pixel_t  pix;
        logic [31:0]          rd;
        logic [31:0]          exp_ctrl;
        logic [7:0]           v;
        int                   row;
        int                   col;
        tc         = tests[t];
        ready_rand = tc.ready_rand;
        // same seed each test, so equal settings give equal images
        pix_seed   = SEED;
        for (row = 0; row < int'(tc.height); row++) begin
            for (col = 0; col < int'(tc.width); col++) begin
                case (tc.pattern)
                    PAT_RAMP: begin
                        pix.r = 8'(col * 16 + row);
                        pix.g = 8'(255 - row * 24 - col);
                        pix.b = 8'((row * 16 + col) * 2);
                    end
                    PAT_STEP: begin
                        v   = (col >= int'(tc.width) / 2) ? 8'd255 : 8'd0;
                        pix = {v, ~v, v};
                    end
                    default: begin
                        pix = 24'($random(pix_seed));
                    end
                endcase
                chk.set_pixel(row * `BICUBIC_MAX_W + col, pix);
                wb_write(bicubic_regs_pkg::PIX_BASE + 8'(row * `BICUBIC_MAX_W + col),
                         {8'd0, pix});
            end
        end
        chk.load_frame(test_names[t], int'(tc.width), int'(tc.height), tc.bypass);
        wb_write(bicubic_regs_pkg::REG_CTRL, ctrl_word(1'b1, tc.bypass, tc.width, tc.height));

        exp_ctrl = ctrl_word(1'b0, tc.bypass, tc.width, tc.height);
        wb_read(bicubic_regs_pkg::REG_CTRL, rd);
        chk.check_reg("ctrl readback", exp_ctrl, rd);

        do begin
            wb_read(bicubic_regs_pkg::REG_STATUS, rd);
        end while (!rd[1]);
        chk.check_reg("status", 32'h2, rd);
        chk.end_frame();
    endtask

    // random ready is high three cycles in four on average
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (ready_rand) begin
            out_ready = ($random(ready_seed) & 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    initial begin
        wb_req     = '0;
        out_ready  = 1'b1;
        ready_rand = 1'b0;
        ready_seed = SEED;
        pix_seed   = SEED;
        @(posedge rst_n);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("errors: %0d in the output stream, %0d in register reads",
                 chk.errors, chk.reg_errors);
        if (chk.errors == 0 && chk.reg_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int budget;
        budget = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            budget += int'(tests[i].width) * int'(tests[i].height) * 4 + 200;
        end
        repeat (budget) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule
